/* hw/audio_channels.sv */
/*
 * audio channel datapath
 * per-channel period and length counters, sample word buffers and sample selection,
 * plus the address of the channel being fetched and the sample of the channel being mixed
 */
module audio_channels #(
    parameter int NCHAN = 4,
    localparam int CHAN_W = (NCHAN > 1) ? $clog2(NCHAN) : 1
) (
    input  logic                                clk,
    input  logic                                reset_i,
    input  logic [NCHAN-1:0]                    enable_i,
    input  logic [NCHAN-1:0]                    restart_i,
    input  logic [NCHAN-1:0]                    tile_i,
    input  audio_pkg::vol_t [NCHAN-1:0]         vol_l_i,
    input  audio_pkg::vol_t [NCHAN-1:0]         vol_r_i,
    input  audio_pkg::period_t [NCHAN-1:0]      period_i,
    input  audio_pkg::addr_t [NCHAN-1:0]        start_i,
    input  audio_pkg::len_t [NCHAN-1:0]         len_i,
    input  logic [CHAN_W-1:0]                   fetch_chan_i,
    output logic                                fetch_need_o,
    input  logic                                word_load_i,
    input  audio_pkg::word_t                    mem_word_i,
    output audio_pkg::addr_t                    mem_addr_o,
    output logic                                mem_tile_o,
    output logic [NCHAN-1:0]                    reload_o,
    audio_mix_if.chan_mp                        mix
);

    localparam int PW = audio_pkg::PERIOD_W;
    localparam int LW = audio_pkg::LEN_W;

    logic [NCHAN-1:0][PW:0]         period_cnt;     // top bit is the underflow flag
    logic [NCHAN-1:0][LW:0]         len_cnt;        // top bit forces a reload
    logic [NCHAN-1:0][LW:0]         len_next;
    audio_pkg::addr_t [NCHAN-1:0]   addr;
    audio_pkg::word_t [NCHAN-1:0]   buf_word;
    audio_pkg::sample_t [NCHAN-1:0] val;            // sample currently playing
    logic [NCHAN-1:0]               tile;
    logic [NCHAN-1:0]               buf_ok;         // buffer holds an unplayed word
    logic [NCHAN-1:0]               second;         // next step plays the low byte
    logic [NCHAN-1:0]               need;           // waiting for a fetch
    logic [NCHAN-1:0]               step;

    always_comb begin
        for (int i = 0; i < NCHAN; i++) begin
            step[i]     = period_cnt[i][PW];
            len_next[i] = len_cnt[i] - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            period_cnt <= '0;
            len_cnt    <= '0;
            addr       <= '0;
            buf_word   <= '0;
            tile       <= '0;
            buf_ok     <= '0;
            second     <= '0;
            need       <= '0;
            reload_o   <= '0;
        end else begin
            for (int i = 0; i < NCHAN; i++) begin
                reload_o[i]   <= 1'b0;
                period_cnt[i] <= period_cnt[i] - 1'b1;

                if (step[i]) begin
                    period_cnt[i] <= {1'b0, period_i[i]} - 1'b1;   // step cycle counts too
                    if (!second[i]) begin
                        second[i] <= 1'b1;
                    end else if (buf_ok[i] || (len_cnt[i][LW] && !need[i])) begin
                        // word used up, fetch the next one
                        second[i] <= 1'b0;
                        buf_ok[i] <= 1'b0;
                        need[i]   <= 1'b1;
                        if (len_cnt[i][LW] || len_next[i][LW]) begin
                            addr[i]     <= start_i[i];
                            tile[i]     <= tile_i[i];
                            len_cnt[i]  <= {1'b0, len_i[i]};
                            reload_o[i] <= 1'b1;
                        end else begin
                            addr[i]    <= addr[i] + 1'b1;
                            len_cnt[i] <= len_next[i];
                        end
                    end
                    // an empty buffer here is an underrun, retried on the next step
                end

                if (word_load_i && fetch_chan_i == CHAN_W'(i)) begin
                    buf_word[i] <= mem_word_i;
                    buf_ok[i]   <= 1'b1;
                    need[i]     <= 1'b0;
                end

                if (restart_i[i]) begin
                    len_cnt[i][LW]    <= 1'b1;      // reload start, tile and length
                    period_cnt[i][PW] <= 1'b1;      // expire period next cycle
                    second[i]         <= 1'b1;
                end

                if (!enable_i[i]) begin
                    len_cnt[i][LW]    <= 1'b1;
                    period_cnt[i][PW] <= 1'b1;
                    second[i]         <= 1'b0;
                    need[i]           <= 1'b0;      // idle channel never requests
                end
            end
        end
    end

    // playing sample, silent while disabled
    always_ff @(posedge clk) begin
        for (int i = 0; i < NCHAN; i++) begin
            if (!enable_i[i]) begin
                val[i] <= '0;
            end else if (step[i]) begin
                val[i] <= second[i] ? buf_word[i][7:0] : buf_word[i][15:8];
            end
        end
    end

    assign fetch_need_o = need[fetch_chan_i];
    assign mem_addr_o   = addr[fetch_chan_i];
    assign mem_tile_o   = tile[fetch_chan_i];

    assign mix.sample = val[mix.mix_chan];
    assign mix.vol_l  = vol_l_i[mix.mix_chan];
    assign mix.vol_r  = vol_r_i[mix.mix_chan];

    // the sequencer only loads channels that asked for a word
    a_no_overrun: assert property (@(posedge clk) disable iff (reset_i)
        word_load_i |-> !buf_ok[fetch_chan_i])
        else $error("audio_channels: word loaded into full buffer of channel %0d",
                    fetch_chan_i);

endmodule

/* hw/audio_dac.sv */
/*
 * audio PDM DAC
 * first-order delta-sigma modulator, carry of the error accumulator is the pulse
 */
module audio_dac (
    input  logic                clk,
    input  logic                reset_i,
    input  audio_pkg::level_t   level_i,
    output logic                pdm_o
);

    audio_pkg::level_t            err_q;
    logic [audio_pkg::LEVEL_W:0]  sum;

    assign sum = {1'b0, err_q} + {1'b0, level_i};

    always_ff @(posedge clk) begin
        if (reset_i) begin
            err_q <= '0;
            pdm_o <= 1'b0;
        end else begin
            err_q <= sum[audio_pkg::LEVEL_W-1:0];   // residue feeds back
            pdm_o <= sum[audio_pkg::LEVEL_W];
        end
    end

endmodule

/* hw/audio_mac.sv */
/*
 * audio mix MAC
 * weights each channel by its volumes, sums a full scan, then clamps to DAC levels
 */
module audio_mac #(
    parameter int NCHAN = 4
) (
    input  logic                clk,
    input  logic                reset_i,
    audio_mix_if.mac_mp         mix,
    input  logic                mix_first_i,
    output audio_pkg::level_t   level_l_o,
    output audio_pkg::level_t   level_r_o
);

    typedef logic signed [audio_pkg::ACC_W-1:0] acc_t;

    audio_pkg::sample_t sample_q;
    audio_pkg::vol_t    vol_l_q;
    audio_pkg::vol_t    vol_r_q;
    acc_t               prod_l;
    acc_t               prod_r;
    acc_t               acc_l;
    acc_t               acc_r;
    logic               accum_q;            // follows the sequencer MULT/ACCUM phase

    function automatic audio_pkg::level_t to_level(input acc_t a);
        if (a < acc_t'(audio_pkg::MIX_MIN)) begin
            return 8'h00;
        end else if (a > acc_t'(audio_pkg::MIX_MAX)) begin
            return 8'hFF;
        end
        return a[audio_pkg::VOL_SHIFT +: 8] ^ 8'h80;    // signed to offset binary
    endfunction

    assign prod_l = acc_t'(sample_q) * acc_t'($signed({1'b0, vol_l_q}));
    assign prod_r = acc_t'(sample_q) * acc_t'($signed({1'b0, vol_r_q}));

    always_ff @(posedge clk) begin
        if (!accum_q) begin
            sample_q <= mix.sample;
            vol_l_q  <= mix.vol_l;
            vol_r_q  <= mix.vol_r;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            accum_q   <= 1'b0;
            acc_l     <= '0;
            acc_r     <= '0;
            level_l_o <= audio_pkg::LEVEL_SILENCE;
            level_r_o <= audio_pkg::LEVEL_SILENCE;
        end else if (!accum_q) begin
            accum_q <= 1'b1;
            if (mix_first_i) begin      // previous scan complete
                level_l_o <= to_level(acc_l);
                level_r_o <= to_level(acc_r);
                acc_l     <= '0;
                acc_r     <= '0;
            end
        end else begin
            accum_q <= 1'b0;
            acc_l   <= acc_l + prod_l;
            acc_r   <= acc_r + prod_r;
        end
    end

endmodule

/* hw/audio_mix_if.sv */
/*
 * audio mix link
 * carries the sample and volumes of the channel being mixed to the MAC
 */
interface audio_mix_if #(
    parameter int NCHAN = 4,
    localparam int CHAN_W = (NCHAN > 1) ? $clog2(NCHAN) : 1
);
    logic [CHAN_W-1:0]   mix_chan;      // scan position from the sequencer
    audio_pkg::sample_t  sample;
    audio_pkg::vol_t     vol_l;
    audio_pkg::vol_t     vol_r;

    modport chan_mp (input mix_chan, output sample, vol_l, vol_r);
    modport mac_mp  (input sample, vol_l, vol_r);

endinterface

/* hw/audio_pkg.sv */
/*
 * audio sample and mixer package
 * widths and vector types of the sample playback path, plus mixer scaling constants
 */
package audio_pkg;

    localparam int SAMPLE_W = 8;
    localparam int VOL_W    = 7;
    localparam int WORD_W   = 16;
    localparam int ADDR_W   = 16;
    localparam int PERIOD_W = 15;           // clocks per sample minus one
    localparam int LEN_W    = 15;           // words per sample block minus one
    localparam int LEVEL_W  = 8;

    typedef logic signed [SAMPLE_W-1:0] sample_t;
    typedef logic [VOL_W-1:0]           vol_t;
    typedef logic [WORD_W-1:0]          word_t;     // two samples, high byte plays first
    typedef logic [ADDR_W-1:0]          addr_t;
    typedef logic [PERIOD_W-1:0]        period_t;
    typedef logic [LEN_W-1:0]           len_t;
    typedef logic [LEVEL_W-1:0]         level_t;    // unsigned, 0x80 is silence

    localparam int ACC_W     = 18;          // mix accumulator width
    localparam int VOL_SHIFT = 6;           // volume 64 is unity gain

    // clamp limits of the accumulated mix
    localparam int MIX_MIN = -128 * (1 << VOL_SHIFT);
    localparam int MIX_MAX = 127 * (1 << VOL_SHIFT);

    localparam level_t LEVEL_SILENCE = 8'h80;

endpackage

/* hw/audio_reg_pkg.sv */
/*
 * audio register package
 * field codes and data layout of the host register write port
 */
package audio_reg_pkg;

    localparam int REG_DATA_W = 16;

    typedef logic [REG_DATA_W-1:0] reg_data_t;

    typedef enum logic [2:0] {
        FLD_CTRL   = 3'd0,      // enable, restart, tile
        FLD_VOL    = 3'd1,      // left 6:0, right 14:8
        FLD_PERIOD = 3'd2,
        FLD_START  = 3'd3,
        FLD_LEN    = 3'd4
    } reg_field_e;

    // FLD_CTRL bit positions
    localparam int CTRL_ENABLE  = 0;
    localparam int CTRL_RESTART = 1;
    localparam int CTRL_TILE    = 2;

endpackage

/* hw/audio_regs.sv */
/*
 * audio channel registers
 * decodes host writes into per-channel settings, restart is a one cycle pulse
 */
module audio_regs #(
    parameter int NCHAN = 4,
    localparam int CHAN_W = (NCHAN > 1) ? $clog2(NCHAN) : 1
) (
    input  logic                                clk,
    input  logic                                reset_i,
    input  logic                                reg_wr_i,
    input  logic [CHAN_W-1:0]                   reg_chan_i,
    input  audio_reg_pkg::reg_field_e           reg_field_i,
    input  audio_reg_pkg::reg_data_t            reg_data_i,
    output logic [NCHAN-1:0]                    enable_o,
    output logic [NCHAN-1:0]                    restart_o,
    output logic [NCHAN-1:0]                    tile_o,
    output audio_pkg::vol_t [NCHAN-1:0]         vol_l_o,
    output audio_pkg::vol_t [NCHAN-1:0]         vol_r_o,
    output audio_pkg::period_t [NCHAN-1:0]      period_o,
    output audio_pkg::addr_t [NCHAN-1:0]        start_o,
    output audio_pkg::len_t [NCHAN-1:0]         len_o
);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            enable_o  <= '0;
            restart_o <= '0;
            tile_o    <= '0;
            vol_l_o   <= '0;
            vol_r_o   <= '0;
            period_o  <= '0;
            start_o   <= '0;
            len_o     <= '0;
        end else begin
            restart_o <= '0;                    // pulse lasts one cycle
            if (reg_wr_i) begin
                case (reg_field_i)
                    audio_reg_pkg::FLD_CTRL: begin
                        enable_o[reg_chan_i]  <= reg_data_i[audio_reg_pkg::CTRL_ENABLE];
                        restart_o[reg_chan_i] <= reg_data_i[audio_reg_pkg::CTRL_RESTART];
                        tile_o[reg_chan_i]    <= reg_data_i[audio_reg_pkg::CTRL_TILE];
                    end
                    audio_reg_pkg::FLD_VOL: begin
                        vol_l_o[reg_chan_i] <= reg_data_i[6:0];
                        vol_r_o[reg_chan_i] <= reg_data_i[14:8];
                    end
                    audio_reg_pkg::FLD_PERIOD: period_o[reg_chan_i] <= reg_data_i[14:0];
                    audio_reg_pkg::FLD_START:  start_o[reg_chan_i]  <= reg_data_i;
                    audio_reg_pkg::FLD_LEN:    len_o[reg_chan_i]    <= reg_data_i[14:0];
                    default: ;                  // unused codes are ignored
                endcase
            end
        end
    end

    // host must address an existing channel
    a_chan_range: assert property (@(posedge clk) disable iff (reset_i)
        reg_wr_i |-> (int'(reg_chan_i) < NCHAN))
        else $error("audio_regs: write to channel %0d of %0d", reg_chan_i, NCHAN);

endmodule

/* hw/audio_seq.sv */
/*
 * audio sequencer
 * round-robin memory fetch FSM and the two-phase mix channel scan
 */
module audio_seq #(
    parameter int NCHAN = 4,
    localparam int CHAN_W = (NCHAN > 1) ? $clog2(NCHAN) : 1
) (
    input  logic                clk,
    input  logic                reset_i,
    output logic                mem_req_o,
    input  logic                mem_ack_i,
    output logic [CHAN_W-1:0]   fetch_chan_o,
    input  logic                fetch_need_i,
    output logic                word_load_o,
    output logic [CHAN_W-1:0]   mix_chan_o,
    output logic                mix_first_o
);

    typedef enum logic {F_ISSUE, F_WAIT} fetch_st_e;
    typedef enum logic {M_MULT, M_ACCUM} mix_st_e;

    fetch_st_e fetch_st;
    mix_st_e   mix_st;

    function automatic logic [CHAN_W-1:0] next_chan(input logic [CHAN_W-1:0] c);
        return (c == CHAN_W'(NCHAN - 1)) ? '0 : c + 1'b1;
    endfunction

    assign word_load_o = (fetch_st == F_WAIT) && mem_req_o && mem_ack_i;   // word valid with ack
    assign mix_first_o = (mix_st == M_MULT) && (mix_chan_o == '0);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            fetch_st     <= F_ISSUE;
            mem_req_o    <= 1'b0;
            fetch_chan_o <= '0;
        end else begin
            case (fetch_st)
                F_ISSUE: begin
                    mem_req_o <= fetch_need_i;
                    fetch_st  <= F_WAIT;
                end
                F_WAIT: begin
                    // no request made, or the arbiter answered
                    if (!mem_req_o || mem_ack_i) begin
                        mem_req_o    <= 1'b0;
                        fetch_chan_o <= next_chan(fetch_chan_o);
                        fetch_st     <= F_ISSUE;
                    end
                end
                default: fetch_st <= F_ISSUE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            mix_st     <= M_MULT;
            mix_chan_o <= '0;
        end else if (mix_st == M_MULT) begin
            mix_st <= M_ACCUM;
        end else begin
            mix_chan_o <= next_chan(mix_chan_o);
            mix_st     <= M_MULT;
        end
    end

    // the fetched channel, and so the memory address, holds until ack
    a_req_stable: assert property (@(posedge clk) disable iff (reset_i)
        (fetch_st == F_WAIT && mem_req_o && !mem_ack_i) |=> $stable(fetch_chan_o) && mem_req_o)
        else $error("audio_seq: fetch channel moved while request pending");

endmodule

/* hw/audio_top.sv */
/*
 * audio playback subsystem top
 * host registers, sample fetch, channel mix and two PDM outputs
 */
module audio_top #(
    parameter int NCHAN = 4,
    localparam int CHAN_W = (NCHAN > 1) ? $clog2(NCHAN) : 1
) (
    input  logic                        clk,
    input  logic                        reset_i,
    input  logic                        reg_wr_i,
    input  logic [CHAN_W-1:0]           reg_chan_i,
    input  audio_reg_pkg::reg_field_e   reg_field_i,
    input  audio_reg_pkg::reg_data_t    reg_data_i,
    output logic                        mem_req_o,
    output logic                        mem_tile_o,
    output audio_pkg::addr_t            mem_addr_o,
    input  logic                        mem_ack_i,
    input  audio_pkg::word_t            mem_word_i,
    output logic [NCHAN-1:0]            reload_o,
    output logic                        pdm_l_o,
    output logic                        pdm_r_o
);

    logic [NCHAN-1:0]               enable;
    logic [NCHAN-1:0]               restart;
    logic [NCHAN-1:0]               tile;
    audio_pkg::vol_t [NCHAN-1:0]    vol_l;
    audio_pkg::vol_t [NCHAN-1:0]    vol_r;
    audio_pkg::period_t [NCHAN-1:0] period;
    audio_pkg::addr_t [NCHAN-1:0]   start;
    audio_pkg::len_t [NCHAN-1:0]    len;
    logic [CHAN_W-1:0]              fetch_chan;
    logic                           fetch_need;
    logic                           word_load;
    logic                           mix_first;
    audio_pkg::level_t              level_l;
    audio_pkg::level_t              level_r;

    audio_mix_if #(.NCHAN(NCHAN)) mix ();

    audio_regs #(.NCHAN(NCHAN)) u_regs (
        .clk, .reset_i, .reg_wr_i, .reg_chan_i, .reg_field_i, .reg_data_i,
        .enable_o(enable), .restart_o(restart), .tile_o(tile), .vol_l_o(vol_l),
        .vol_r_o(vol_r), .period_o(period), .start_o(start), .len_o(len)
    );

    audio_channels #(.NCHAN(NCHAN)) u_channels (
        .clk, .reset_i,
        .enable_i(enable), .restart_i(restart), .tile_i(tile), .vol_l_i(vol_l),
        .vol_r_i(vol_r), .period_i(period), .start_i(start), .len_i(len),
        .fetch_chan_i(fetch_chan), .fetch_need_o(fetch_need), .word_load_i(word_load),
        .mem_word_i, .mem_addr_o, .mem_tile_o, .reload_o, .mix(mix.chan_mp)
    );

    audio_seq #(.NCHAN(NCHAN)) u_seq (
        .clk, .reset_i, .mem_req_o, .mem_ack_i,
        .fetch_chan_o(fetch_chan), .fetch_need_i(fetch_need), .word_load_o(word_load),
        .mix_chan_o(mix.mix_chan), .mix_first_o(mix_first)
    );

    audio_mac #(.NCHAN(NCHAN)) u_mac (
        .clk, .reset_i, .mix(mix.mac_mp), .mix_first_i(mix_first),
        .level_l_o(level_l), .level_r_o(level_r)
    );

    audio_dac u_dac_l (.clk, .reset_i, .level_i(level_l), .pdm_o(pdm_l_o));
    audio_dac u_dac_r (.clk, .reset_i, .level_i(level_r), .pdm_o(pdm_r_o));

endmodule

/* run.sh */
#!/bin/sh
# build and run the audio testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module tb_audio -o tb_audio
./obj_dir/tb_audio > sim.log
cat sim.log

if grep -q "Test completed successfully" sim.log; then
    exit 0
fi
exit 1

/* src.f */
hw/audio_pkg.sv
hw/audio_reg_pkg.sv
hw/audio_mix_if.sv
hw/audio_regs.sv
hw/audio_channels.sv
hw/audio_seq.sv
hw/audio_mac.sv
hw/audio_dac.sv
hw/audio_top.sv
verif/sample_mem.sv
verif/tb_audio.sv

/* verif/sample_mem.sv */
/*
 * sample memory model
 * answers fetch requests after a random delay of 0 to 5 cycles, one word per ack
 */
module sample_mem (
    input  logic        clk,
    input  logic        reset_i,
    input  logic        req_i,
    input  logic [15:0] addr_i,
    output logic        ack_o,
    output logic [15:0] word_o
);
    timeunit 1ns;
    timeprecision 1ps;

    integer seed;
    int     wait_cnt;
    logic   busy;

    initial begin
        seed     = 57;
        ack_o    = 1'b0;
        word_o   = 16'h0000;
        busy     = 1'b0;
        wait_cnt = 0;
    end

    // outputs change 1 ns after the rising edge
    always begin
        @(posedge clk);
        #1;
        if (reset_i || ack_o) begin
            ack_o = 1'b0;
            busy  = 1'b0;
        end else if (req_i) begin
            if (!busy) begin
                busy     = 1'b1;
                wait_cnt = int'($unsigned($random(seed)) % 6);
            end
            if (wait_cnt == 0) begin
                ack_o  = 1'b1;
                word_o = addr_i[15] ? 16'hE0E0 : 16'h2020;  // negative or positive pair
            end else begin
                wait_cnt--;
            end
        end
    end

endmodule

/* verif/tb_audio.sv */
/*
 * audio playback testbench
 * programs channels, models the expected fetch order and reloads, checks PDM density
 */
module tb_audio;
    timeunit 1ns;
    timeprecision 1ps;

    logic clk = 1'b0;
    logic reset_i = 1'b1;
    logic reg_wr = 1'b0;
    logic [1:0] reg_chan = 2'd0;
    audio_reg_pkg::reg_field_e reg_field = audio_reg_pkg::FLD_CTRL;
    logic [15:0] reg_data = 16'h0000;
    logic mem_req_o, mem_tile_o, mem_ack_i, pdm_l_o, pdm_r_o;
    logic [15:0] mem_addr_o, mem_word_i;
    logic [3:0] reload_o;

    int errors = 0;
    int phase = 0;          // 1 first mix, 2 changeover, 3 saturating mix
    int phase_seen = 0;
    int restarts = 0;
    int restart_seen = 0;
    logic rst_q = 1'b0;
    logic [15:0] start_of [4];
    logic [15:0] len_of [4];
    logic [15:0] exp_addr [4];
    logic tile_of [4];
    int reloads [4];
    int s_acks [4];
    logic [1:0] ack_ch;
    logic in_region, ack_ok;

    audio_top #(.NCHAN(4)) uut (
        .clk, .reset_i, .reg_wr_i(reg_wr), .reg_chan_i(reg_chan), .reg_field_i(reg_field),
        .reg_data_i(reg_data), .mem_req_o, .mem_tile_o, .mem_addr_o, .mem_ack_i,
        .mem_word_i, .reload_o, .pdm_l_o, .pdm_r_o
    );

    sample_mem u_mem (
        .clk, .reset_i, .req_i(mem_req_o), .addr_i(mem_addr_o),
        .ack_o(mem_ack_i), .word_o(mem_word_i)
    );

    always #2 clk = ~clk;

    // channel index comes from the address region, 0x?1xx is channel 0
    assign in_region = (mem_addr_o[10:8] >= 3'd1) && (mem_addr_o[10:8] <= 3'd4);
    assign ack_ch = 2'(mem_addr_o[10:8] - 3'd1);
    assign ack_ok = mem_req_o && mem_ack_i && (phase == 1 || phase == 3);

    always @(posedge clk) begin
        rst_q <= reset_i;
        for (int i = 0; i < 4; i++) begin
            if (reload_o[i]) reloads[i]++;
        end
        if (phase != phase_seen) begin
            phase_seen = phase;
            for (int i = 0; i < 4; i++) begin
                exp_addr[i] = start_of[i];
                reloads[i]  = 0;
                s_acks[i]   = 0;
            end
        end
        if (restarts != restart_seen) begin
            restart_seen = restarts;
            exp_addr[0]  = start_of[0];
        end
        if (ack_ok && in_region) begin
            if (mem_addr_o == start_of[ack_ch]) s_acks[ack_ch]++;
            exp_addr[ack_ch] = (mem_addr_o == start_of[ack_ch] + len_of[ack_ch]) ?
                               start_of[ack_ch] : mem_addr_o + 16'd1;
        end
    end

    a_reset: assert property (@(posedge clk) rst_q |=>
        (!mem_req_o && reload_o == 4'd0 && !pdm_l_o && !pdm_r_o))
        else begin
            errors++;
            $display("ERROR reset_state: expected 0, actual req %b reload %h pdm %b%b",
                     $sampled(mem_req_o), $sampled(reload_o), $sampled(pdm_l_o),
                     $sampled(pdm_r_o));
        end

    a_region: assert property (@(posedge clk) disable iff (reset_i) ack_ok |-> in_region)
        else begin
            errors++;
            $display("ERROR fetch_region: address %h is outside every channel",
                     $sampled(mem_addr_o));
        end

    a_addr: assert property (@(posedge clk) disable iff (reset_i) (ack_ok && in_region) |->
        (mem_addr_o == exp_addr[ack_ch] && mem_tile_o == tile_of[ack_ch]))
        else begin
            errors++;
            $display("ERROR fetch_addr: expected %h tile %b, actual %h tile %b",
                     $sampled(exp_addr[ack_ch]), $sampled(tile_of[ack_ch]),
                     $sampled(mem_addr_o), $sampled(mem_tile_o));
        end

    a_reload: assert property (@(posedge clk) disable iff (reset_i)
        (ack_ok && in_region && mem_addr_o == start_of[ack_ch]) |->
        (reloads[ack_ch] == s_acks[ack_ch] + 1))
        else begin
            errors++;
            $display("ERROR reload_count: expected %0d, actual %0d",
                     $sampled(s_acks[ack_ch]) + 1, $sampled(reloads[ack_ch]));
        end

    a_hold: assert property (@(posedge clk) disable iff (reset_i) (mem_req_o && !mem_ack_i)
        |=> (mem_req_o && $stable(mem_addr_o) && $stable(mem_tile_o)))
        else begin
            errors++;
            $display("ERROR req_stable: request dropped or address moved before ack");
        end

    a_disabled: assert property (@(posedge clk) disable iff (reset_i)
        (mem_req_o && phase == 1) |-> (mem_addr_o[10:8] inside {3'd1, 3'd2}))
        else begin
            errors++;
            $display("ERROR disabled_chan: expected channel 0 or 1, actual address %h",
                     $sampled(mem_addr_o));
        end

    task automatic tick(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic write_reg(input int ch, input audio_reg_pkg::reg_field_e fld,
                             input logic [15:0] data);
        reg_wr    = 1'b1;
        reg_chan  = 2'(ch);
        reg_field = fld;
        reg_data  = data;
        tick(1);
        reg_wr = 1'b0;
    endtask

    // clamp and offset of a mixed sum, as the level rule describes it
    function automatic int expected_level(input int sum);
        if (sum < -128 * 64) return 0;
        if (sum > 127 * 64) return 255;
        return ((sum >>> 6) & 255) ^ 128;
    endfunction

    task automatic check_density(input string name, input int level);
        int ones_l;
        int ones_r;
        ones_l = 0;
        ones_r = 0;
        repeat (256) begin
            tick(1);
            if (pdm_l_o) ones_l++;
            if (pdm_r_o) ones_r++;
        end
        assert (ones_l >= level - 1 && ones_l <= level + 1 &&
                ones_r >= level - 1 && ones_r <= level + 1)
        else begin
            errors++;
            $display("ERROR %s: expected %0d, actual left %0d right %0d",
                     name, level, ones_l, ones_r);
        end
    endtask

    initial begin
        #(20 * 4 * 4000 * 4);
        $display("ERROR watchdog: simulation ran past its time limit");
        $display("Test failed");
        $finish;
    end

    initial begin
        start_of = '{16'h0100, 16'h0200, 16'h0300, 16'h0400};
        len_of   = '{16'd5, 16'd2, 16'd3, 16'd3};
        tile_of  = '{1'b1, 1'b0, 1'b0, 1'b0};
        tick(4);
        reset_i = 1'b0;
        tick(4);
        for (int i = 0; i < 4; i++) begin
            write_reg(i, audio_reg_pkg::FLD_PERIOD, (i == 1) ? 16'd11 : 16'd7);
            write_reg(i, audio_reg_pkg::FLD_START, start_of[i]);
            write_reg(i, audio_reg_pkg::FLD_LEN, len_of[i]);
        end
        write_reg(0, audio_reg_pkg::FLD_VOL, 16'h2020);     // 32 left and right
        write_reg(1, audio_reg_pkg::FLD_VOL, 16'h1010);
        phase = 1;
        write_reg(0, audio_reg_pkg::FLD_CTRL, 16'h0005);
        write_reg(1, audio_reg_pkg::FLD_CTRL, 16'h0001);
        // restart channel 0 in the middle of its block
        do @(posedge clk); while (!(mem_req_o && mem_ack_i && mem_addr_o == 16'h0102));
        #1;
        restarts++;
        write_reg(0, audio_reg_pkg::FLD_CTRL, 16'h0007);
        tick(3000);
        check_density("pdm_density_mix", expected_level(32 * 32 + 32 * 16));

        phase = 2;
        write_reg(0, audio_reg_pkg::FLD_CTRL, 16'h0000);
        write_reg(1, audio_reg_pkg::FLD_CTRL, 16'h0000);
        tick(100);
        start_of = '{16'h8100, 16'h8200, 16'h8300, 16'h8400};
        len_of   = '{16'd3, 16'd4, 16'd5, 16'd6};
        tile_of  = '{1'b0, 1'b1, 1'b0, 1'b1};
        for (int i = 0; i < 4; i++) begin
            write_reg(i, audio_reg_pkg::FLD_PERIOD, 16'd7);
            write_reg(i, audio_reg_pkg::FLD_START, start_of[i]);
            write_reg(i, audio_reg_pkg::FLD_LEN, len_of[i]);
            write_reg(i, audio_reg_pkg::FLD_VOL, 16'h7F7F);
        end
        phase = 3;
        for (int i = 0; i < 4; i++) begin
            write_reg(i, audio_reg_pkg::FLD_CTRL, tile_of[i] ? 16'h0007 : 16'h0003);
        end
        tick(3000);
        check_density("pdm_density_sat", expected_level(4 * -32 * 127));

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
